/* cardinal_pkg.sv */
package cardinal_pkg;

    //--------------------------------------------------------------------------
    // basic widths, all msb-first like the rest of the core
    typedef logic [0:31] addr_t;     // instruction word or byte address
    typedef logic [0:63] data_t;     // one vector register
    typedef logic [0:4]  reg_idx_t;  // register index

    // major opcodes
    typedef enum logic [0:5] {
        op_alu  = 6'b101010,  // r-type vector alu op
        op_bez  = 6'b100010,  // branch if rd is zero
        op_bnez = 6'b100011,  // branch if rd is not zero
        op_nop  = 6'b111100,
        op_ld   = 6'b100000,
        op_sd   = 6'b100001
    } opcode_e;

    // alu function field
    typedef enum logic [0:5] {
        f_vand = 6'b000001,
        f_vor  = 6'b000010,
        f_vxor = 6'b000011,
        f_vnot = 6'b000100,  // unary on ra
        f_vmov = 6'b000101,  // copies ra
        f_vadd = 6'b000110,
        f_vsub = 6'b000111
    } func_e;

    // selective write modes
    typedef enum logic [0:2] {
        mode_a = 3'b000,  // all bytes
        mode_u = 3'b001,  // upper word
        mode_d = 3'b010,  // lower word
        mode_e = 3'b011,  // even bytes
        mode_o = 3'b100   // odd bytes
    } ppp_e;

    // lane width
    typedef enum logic [0:1] {
        ww_byte   = 2'b00,
        ww_half   = 2'b01,
        ww_word   = 2'b10,
        ww_double = 2'b11
    } ww_e;

    //--------------------------------------------------------------------------
    // instruction word, two decodings of the same 32 bits
    typedef struct packed {
        opcode_e  opcode;
        reg_idx_t rd;
        reg_idx_t ra;
        reg_idx_t rb;
        ppp_e     ppp;
        ww_e      ww;
        func_e    func;
    } r_fmt_t;

    typedef struct packed {
        opcode_e     opcode;
        reg_idx_t    rd;
        reg_idx_t    ra;
        logic [0:15] imm;  // memory address or branch target
    } m_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        m_fmt_t m_fmt;
    } instr_u;

    // decode -> execute register
    typedef struct packed {
        data_t    op_a;       // port 0 operand, store data for sd
        data_t    op_b;
        reg_idx_t rd;
        ppp_e     ppp;
        ww_e      ww;
        func_e    func;
        logic     rf_we;
        logic     mem_en;
        logic     mem_wr_en;
        logic     mem_stall;  // sd, or ld to a nonzero rd
    } dx_t;

    // write-back bus into the register file
    typedef struct packed {
        logic     we;
        reg_idx_t rd;
        ppp_e     ppp;
        data_t    data;
    } wb_t;

    // byte-lane mask of a ppp mode, byte 0 is the msb byte
    function automatic data_t lane_mask(ppp_e ppp);
        logic [0:7] sel;
        data_t      mask;
        case (ppp)
            mode_a:  sel = 8'b1111_1111;
            mode_u:  sel = 8'b1111_0000;
            mode_d:  sel = 8'b0000_1111;
            mode_e:  sel = 8'b1010_1010;
            mode_o:  sel = 8'b0101_0101;
            default: sel = 8'b0000_0000;  // undefined modes write nothing
        endcase
        for (int i = 0; i < 8; i++)
            mask[8*i +: 8] = {8{sel[i]}};
        return mask;
    endfunction

endpackage

/* instr_fetch.sv */
`timescale 1ns/1ps

module instr_fetch import cardinal_pkg::*; #(
    parameter addr_t pc_reset_value = 32'h0
) (
    input  logic   clk,
    input  logic   reset,
    input  logic   stall,     // memory stall from execute
    input  logic   br_taken,  // branch resolved in decode
    input  addr_t  br_addr,
    input  addr_t  instr_in,  // word from instruction memory
    output addr_t  pc,
    output instr_u fetched    // fetch/decode register
);

    // program counter, reset first, then stall, then branch
    always_ff @(posedge clk)
    begin
        if (reset)
            pc <= pc_reset_value;
        else if (!stall)
        begin
            if (br_taken)
                pc <= br_addr;    // absolute target
            else
                pc <= pc + 32'd4;
        end
    end

    // fetch/decode register
    always_ff @(posedge clk)
    begin
        if (reset)
            fetched <= {op_nop, 26'd0};      // start with a bubble
        else if (!stall)
        begin
            if (br_taken)
                fetched.r_fmt.opcode <= op_nop;  // kill the word fetched behind the branch
            else
                fetched <= instr_in;
        end
    end

endmodule

/* register_file.sv */
`timescale 1ns/1ps

module register_file import cardinal_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  wb_t      wb,         // write port from result stage
    input  reg_idx_t rd_addr_0,
    input  reg_idx_t rd_addr_1,
    output data_t    rd_data_0,
    output data_t    rd_data_1
);

    data_t regs [0:31];  // register 0 is writable too
    data_t wr_mask;      // byte lanes touched by this write

    assign wr_mask = lane_mask(wb.ppp);

    // read with write-through of a same-cycle write, lane by lane
    function automatic data_t read_port(data_t stored, reg_idx_t addr, wb_t w, data_t m);
        if (w.we && (w.rd == addr))
            return (stored & ~m) | (w.data & m);
        return stored;
    endfunction

    //--------------------------------------------------------------------------
    // write port
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end
        else if (wb.we)
        begin
            // unselected lanes keep their old value
            regs[wb.rd] <= (regs[wb.rd] & ~wr_mask) | (wb.data & wr_mask);
        end
    end

    //--------------------------------------------------------------------------
    // two combinational read ports
    assign rd_data_0 = read_port(regs[rd_addr_0], rd_addr_0, wb, wr_mask);
    assign rd_data_1 = read_port(regs[rd_addr_1], rd_addr_1, wb, wr_mask);

endmodule

/* decode_stage.sv */
`timescale 1ns/1ps

module decode_stage import cardinal_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     stall,
    input  instr_u   fetched,
    input  data_t    rd_data_0,
    input  data_t    rd_data_1,
    input  data_t    fwd_data,       // write data of the instruction in execute
    output reg_idx_t rd_addr_0,
    output reg_idx_t rd_addr_1,
    output logic     br_taken,
    output addr_t    br_addr,
    output logic     dmem_en,
    output logic     dmem_wr_en,
    output addr_t    dmem_addr,
    output data_t    dmem_data_out,
    output dx_t      dx              // decode/execute register
);

    // one memory request, live or held in the shadow register
    typedef struct packed {
        logic  en;
        logic  wr_en;
        addr_t addr;
        data_t data;
    } mem_req_t;

    opcode_e     opcode;
    reg_idx_t    rd;
    ppp_e        ppp;
    logic [0:15] imm;
    logic        rf_we, mem_en, mem_wr_en, mem_stall;
    logic        haz_0, haz_1;     // execute rd matches a read port
    data_t       fwd_mask;
    data_t       opnd_0, opnd_1;   // operands after forwarding
    mem_req_t    req, shadow, req_out;
    dx_t         dx_next;

    //--------------------------------------------------------------------------
    // field decode, r view for registers and the m view for the immediate
    assign opcode = fetched.r_fmt.opcode;
    assign rd     = fetched.m_fmt.rd;
    assign imm    = fetched.m_fmt.imm;
    assign ppp    = (opcode == op_ld) ? mode_a : fetched.r_fmt.ppp;  // loads write all lanes

    // control
    always_comb
    begin
        rf_we     = 1'b0;
        mem_en    = 1'b0;
        mem_wr_en = 1'b0;
        case (opcode)
            op_alu: rf_we = 1'b1;    // writes to r0 are allowed
            op_ld:
            begin
                rf_we  = (rd != 5'd0);  // ld to r0 leaves the register file alone
                mem_en = 1'b1;
            end
            op_sd:
            begin
                mem_en    = 1'b1;
                mem_wr_en = 1'b1;
            end
            default: rf_we = 1'b0;   // branches, nop and unknown opcodes
        endcase
    end

    // execute will hold the pipe for one cycle on this
    assign mem_stall = (opcode == op_sd) || ((opcode == op_ld) && (rd != 5'd0));

    // port 0 reads rd for store data and branch test
    assign rd_addr_0 = ((opcode == op_sd) || (opcode == op_bez) || (opcode == op_bnez))
                       ? rd : fetched.r_fmt.ra;
    assign rd_addr_1 = fetched.r_fmt.rb;

    //--------------------------------------------------------------------------
    // hazard detect and forwarding from execute
    assign haz_0    = dx.rf_we && (dx.rd != 5'd0) && (dx.rd == rd_addr_0);
    assign haz_1    = dx.rf_we && (dx.rd != 5'd0) && (dx.rd == rd_addr_1);
    assign fwd_mask = lane_mask(dx.ppp);  // only the lanes that instruction writes

    assign opnd_0 = haz_0 ? ((rd_data_0 & ~fwd_mask) | (fwd_data & fwd_mask)) : rd_data_0;
    assign opnd_1 = haz_1 ? ((rd_data_1 & ~fwd_mask) | (fwd_data & fwd_mask)) : rd_data_1;

    // branch resolve
    assign br_addr  = {16'd0, imm};
    assign br_taken = ((opcode == op_bez) && (opnd_0 == '0)) ||
                      ((opcode == op_bnez) && (opnd_0 != '0));

    //--------------------------------------------------------------------------
    // memory request, issued from decode
    assign req.en    = mem_en;
    assign req.wr_en = mem_wr_en;
    assign req.addr  = {16'd0, imm};  // zero-extended immediate
    assign req.data  = opnd_0;

    // shadow keeps the request alive while execute stalls
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            shadow.en    <= 1'b0;
            shadow.wr_en <= 1'b0;
        end
        else if (!stall)
            shadow <= req;
    end

    assign req_out       = stall ? shadow : req;
    assign dmem_en       = req_out.en;
    assign dmem_wr_en    = req_out.wr_en;
    assign dmem_addr     = req_out.addr;
    assign dmem_data_out = req_out.data;

    //--------------------------------------------------------------------------
    // decode/execute register
    always_comb
    begin
        dx_next.op_a      = opnd_0;
        dx_next.op_b      = opnd_1;
        dx_next.rd        = rd;
        dx_next.ppp       = ppp;
        dx_next.ww        = fetched.r_fmt.ww;
        dx_next.func      = fetched.r_fmt.func;
        dx_next.rf_we     = rf_we;
        dx_next.mem_en    = mem_en;
        dx_next.mem_wr_en = mem_wr_en;
        dx_next.mem_stall = mem_stall;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            dx.rf_we     <= 1'b0;  // behaves as a nop
            dx.mem_en    <= 1'b0;
            dx.mem_wr_en <= 1'b0;
            dx.mem_stall <= 1'b0;
        end
        else if (!stall)
            dx <= dx_next;
    end

endmodule

/* execute_stage.sv */
`timescale 1ns/1ps

module execute_stage import cardinal_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  dx_t   dx,
    output data_t alu_res,
    output logic  stall     // one-cycle memory stall
);

    logic stall_flag;  // set during the second cycle of a memory op

    // lane-wise add or subtract, carry never crosses a lane edge
    function automatic data_t lane_addsub(data_t a, data_t b, logic sub, ww_e ww);
        data_t      res;
        logic [0:7] bb;
        logic [8:0] sum;
        logic       carry;
        int         nb;
        nb    = 1 << ww;  // bytes per lane
        carry = sub;
        for (int i = 7; i >= 0; i--)  // lsb byte first
        begin
            if (((i + 1) % nb) == 0)
                carry = sub;          // lowest byte of a lane
            bb  = sub ? ~b[8*i +: 8] : b[8*i +: 8];
            sum = {1'b0, a[8*i +: 8]} + {1'b0, bb} + carry;
            res[8*i +: 8] = sum[7:0];
            carry = sum[8];
        end
        return res;
    endfunction

    //--------------------------------------------------------------------------
    // alu, logic ops have no lanes to worry about
    always_comb
    begin
        case (dx.func)
            f_vand:  alu_res = dx.op_a & dx.op_b;
            f_vor:   alu_res = dx.op_a | dx.op_b;
            f_vxor:  alu_res = dx.op_a ^ dx.op_b;
            f_vnot:  alu_res = ~dx.op_a;
            f_vmov:  alu_res = dx.op_a;
            f_vadd:  alu_res = lane_addsub(dx.op_a, dx.op_b, 1'b0, dx.ww);
            f_vsub:  alu_res = lane_addsub(dx.op_a, dx.op_b, 1'b1, dx.ww);  // ra minus rb
            default: alu_res = '0;
        endcase
    end

    //--------------------------------------------------------------------------
    // memory stall
    // flag flips on each cycle a memory op sits here, so stall is high
    // only in the first of its two cycles
    always_ff @(posedge clk)
    begin
        if (reset)
            stall_flag <= 1'b0;
        else if (dx.mem_stall)
            stall_flag <= ~stall_flag;
    end

    assign stall = dx.mem_stall && !stall_flag;

endmodule

/* result_stage.sv */
`timescale 1ns/1ps

module result_stage import cardinal_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  stall,
    input  dx_t   dx,
    input  data_t alu_res,
    input  data_t dmem_data_in,  // valid the cycle after the access
    output data_t fwd_data,      // also goes back to decode
    output wb_t   wb
);

    // loads take the memory word, everything else the alu result
    assign fwd_data = dx.mem_en ? dmem_data_in : alu_res;

    // execute/result register
    always_ff @(posedge clk)
    begin
        if (reset)
            wb.we <= 1'b0;
        else if (stall)
            wb.we <= 1'b0;        // bubble, payload left as is
        else
        begin
            wb.we   <= dx.rf_we;
            wb.rd   <= dx.rd;
            wb.ppp  <= dx.ppp;
            wb.data <= fwd_data;
        end
    end

endmodule

/* cardinal_cpu.sv */
`timescale 1ns/1ps

module cardinal_cpu import cardinal_pkg::*; #(
    parameter addr_t pc_reset_value = 32'h0
) (
    input  logic  clk,
    input  logic  reset,          // synchronous, active high
    input  addr_t instr_in,       // answered in the same cycle
    input  data_t dmem_data_in,
    output addr_t instr_addr,
    output addr_t dmem_addr,
    output data_t dmem_data_out,
    output logic  dmem_en,
    output logic  dmem_wr_en
);

    logic     stall;       // from execute only
    logic     br_taken;
    addr_t    br_addr;
    instr_u   fetched;
    reg_idx_t rd_addr_0, rd_addr_1;
    data_t    rd_data_0, rd_data_1;
    data_t    alu_res;
    data_t    fwd_data;    // execute write data back to decode
    dx_t      dx;
    wb_t      wb;

    //--------------------------------------------------------------------------
    // fetch
    instr_fetch #(
        .pc_reset_value(pc_reset_value)
    ) i_instr_fetch (
        .clk      (clk),
        .reset    (reset),
        .stall    (stall),
        .br_taken (br_taken),
        .br_addr  (br_addr),
        .instr_in (instr_in),
        .pc       (instr_addr),
        .fetched  (fetched)
    );

    register_file i_register_file (
        .clk       (clk),
        .reset     (reset),
        .wb        (wb),
        .rd_addr_0 (rd_addr_0),
        .rd_addr_1 (rd_addr_1),
        .rd_data_0 (rd_data_0),
        .rd_data_1 (rd_data_1)
    );

    //--------------------------------------------------------------------------
    // decode, execute, result
    decode_stage i_decode_stage (
        .clk           (clk),
        .reset         (reset),
        .stall         (stall),
        .fetched       (fetched),
        .rd_data_0     (rd_data_0),
        .rd_data_1     (rd_data_1),
        .fwd_data      (fwd_data),
        .rd_addr_0     (rd_addr_0),
        .rd_addr_1     (rd_addr_1),
        .br_taken      (br_taken),
        .br_addr       (br_addr),
        .dmem_en       (dmem_en),
        .dmem_wr_en    (dmem_wr_en),
        .dmem_addr     (dmem_addr),
        .dmem_data_out (dmem_data_out),
        .dx            (dx)
    );

    execute_stage i_execute_stage (
        .clk     (clk),
        .reset   (reset),
        .dx      (dx),
        .alu_res (alu_res),
        .stall   (stall)
    );

    result_stage i_result_stage (
        .clk          (clk),
        .reset        (reset),
        .stall        (stall),
        .dx           (dx),
        .alu_res      (alu_res),
        .dmem_data_in (dmem_data_in),
        .fwd_data     (fwd_data),
        .wb           (wb)
    );

endmodule

/* cardinal_cpu_chk.sv */
`timescale 1ns/1ps

module cardinal_cpu_chk import cardinal_pkg::*; (
    input logic  clk,
    input logic  reset,
    input logic  stall,
    input logic  dmem_en,
    input logic  dmem_wr_en,
    input addr_t dmem_addr,
    input data_t dmem_data_out
);

    int fail_count = 0;  // read by the testbench at the end of each test

    // memory stall is one cycle, never two
    a_stall_single: assert property (@(posedge clk) disable iff (reset) stall |=> !stall)
        else
        begin
            $error("stall high two cycles in a row");
            fail_count++;
        end

    // a write is always an enabled access
    a_wr_needs_en: assert property (@(posedge clk) disable iff (reset) dmem_wr_en |-> dmem_en)
        else
        begin
            $error("dmem_wr_en without dmem_en");
            fail_count++;
        end

    // shadow register repeats the request of the cycle before
    a_req_held: assert property (@(posedge clk) disable iff (reset)
        stall |-> ($stable(dmem_en) && $stable(dmem_wr_en) &&
                   $stable(dmem_addr) && $stable(dmem_data_out)))
        else
        begin
            $error("memory request changed during stall");
            fail_count++;
        end

    // pipeline is empty right after reset
    a_quiet_after_reset: assert property (@(posedge clk) reset |=> !dmem_en)
        else
        begin
            $error("dmem_en high in the cycle after reset");
            fail_count++;
        end

endmodule

bind cardinal_cpu cardinal_cpu_chk i_cardinal_cpu_chk (
    .clk           (clk),
    .reset         (reset),
    .stall         (stall),
    .dmem_en       (dmem_en),
    .dmem_wr_en    (dmem_wr_en),
    .dmem_addr     (dmem_addr),
    .dmem_data_out (dmem_data_out)
);

/* cardinal_scoreboard.sv */
`timescale 1ns/1ps

module cardinal_scoreboard import cardinal_pkg::*; (
    input logic  clk,
    input logic  reset,
    input logic  stall,          // second issue of a store is ignored
    input logic  dmem_en,
    input logic  dmem_wr_en,
    input addr_t dmem_addr,
    input data_t dmem_data_out
);

    instr_u prog [0:63];         // filled by the testbench
    data_t  init_mem [0:255];
    addr_t  exp_addr [$];        // expected stores, in program order
    data_t  exp_data [$];
    addr_t  halt_pc;
    logic   armed = 1'b0;
    int     errors = 0;
    int     matched = 0;
    int     exp_stalls = 0;      // sd and ld to a nonzero rd in the model
    int     stall_cycles = 0;    // stall cycles seen on the core

    // ------------------------------------------------------------------------
    // reference arithmetic, lane by lane with no carry between lanes
    function automatic logic [63:0] lane_math(logic [63:0] a, logic [63:0] b, logic sub,
                                              logic [1:0] ww);
        logic [63:0] r;
        logic [63:0] m;
        int          w;
        w = 8 << ww;                                    // lane width in bits
        m = (w == 64) ? '1 : ((64'd1 << w) - 64'd1);
        r = '0;
        for (int s = 0; s < 64; s += w)
            r |= ((sub ? ((a >> s) - (b >> s)) : ((a >> s) + (b >> s))) & m) << s;
        return r;
    endfunction

    // byte 0 is the most significant byte
    function automatic logic [63:0] write_sel(logic [2:0] ppp);
        case (ppp)
            3'd0:    return 64'hFFFF_FFFF_FFFF_FFFF;
            3'd1:    return 64'hFFFF_FFFF_0000_0000;    // upper word
            3'd2:    return 64'h0000_0000_FFFF_FFFF;
            3'd3:    return 64'hFF00_FF00_FF00_FF00;    // even bytes
            3'd4:    return 64'h00FF_00FF_00FF_00FF;
            default: return 64'h0;
        endcase
    endfunction

    function automatic int pending();
        return exp_addr.size();
    endfunction

    // ------------------------------------------------------------------------
    // in-order run of the program, no timing at all
    task automatic run_model(input addr_t base);
        logic [63:0] regs [0:31];
        logic [63:0] mem [0:255];
        logic [63:0] a, b, res, m;
        instr_u      ins;
        addr_t       pc, target;
        int          idx, step;
        logic        taken, halted;
        exp_addr.delete();
        exp_data.delete();
        exp_stalls   = 0;
        stall_cycles = 0;
        for (int i = 0; i < 32; i++)
            regs[i] = '0;
        for (int i = 0; i < 256; i++)
            mem[i] = init_mem[i];
        pc     = base;
        halt_pc = '1;                                   // unreachable unless the model halts
        halted = 1'b0;
        for (step = 0; step < 4096 && !halted; step++)
        begin
            idx    = int'((pc - base) >> 2);
            ins    = (idx < 64) ? prog[idx] : {op_nop, 26'd0};
            taken  = 1'b0;
            target = {16'd0, ins.m_fmt.imm};
            a      = regs[ins.r_fmt.ra];
            b      = regs[ins.r_fmt.rb];
            case (ins.r_fmt.opcode)
                op_alu:
                begin
                    case (ins.r_fmt.func)
                        f_vand:  res = a & b;
                        f_vor:   res = a | b;
                        f_vxor:  res = a ^ b;
                        f_vnot:  res = ~a;
                        f_vmov:  res = a;
                        f_vadd:  res = lane_math(a, b, 1'b0, ins.r_fmt.ww);
                        f_vsub:  res = lane_math(a, b, 1'b1, ins.r_fmt.ww);
                        default: res = '0;
                    endcase
                    m = write_sel(ins.r_fmt.ppp);
                    regs[ins.r_fmt.rd] = (regs[ins.r_fmt.rd] & ~m) | (res & m);
                end
                op_ld:
                    if (ins.m_fmt.rd != 5'd0)           // ld r0 changes nothing
                    begin
                        regs[ins.m_fmt.rd] = mem[ins.m_fmt.imm[8:15]];
                        exp_stalls++;
                    end
                op_sd:
                begin
                    mem[ins.m_fmt.imm[8:15]] = regs[ins.m_fmt.rd];
                    exp_addr.push_back(target);
                    exp_data.push_back(regs[ins.m_fmt.rd]);
                    exp_stalls++;                       // one stall cycle per store
                end
                op_bez:  taken = (regs[ins.m_fmt.rd] == '0);
                op_bnez: taken = (regs[ins.m_fmt.rd] != '0);
                default: taken = 1'b0;
            endcase
            if (taken && target == pc)
            begin
                halt_pc = pc;                           // branch to itself
                halted  = 1'b1;
            end
            pc = taken ? target : pc + 32'd4;
        end
    endtask

    // memory stalls of the run against the model's count
    task automatic check_stalls();
        if (stall_cycles != exp_stalls)
        begin
            $display("ERR stall cycles expected %h actual %h", exp_stalls, stall_cycles);
            errors++;
        end
    endtask

    // ------------------------------------------------------------------------
    // compare every store as it leaves the core
    always @(posedge clk)
    begin
        if (armed && !reset && dmem_en && dmem_wr_en && !stall)
        begin
            if (exp_addr.size() == 0)
            begin
                $display("store to address %h that the program never makes", dmem_addr);
                errors++;
            end
            else
            begin
                if (dmem_addr !== exp_addr[0])
                begin
                    $display("ERR dmem_addr expected %h actual %h", exp_addr[0], dmem_addr);
                    errors++;
                end
                if (dmem_data_out !== exp_data[0])
                begin
                    $display("ERR dmem_data_out expected %h actual %h", exp_data[0],
                             dmem_data_out);
                    errors++;
                end
                void'(exp_addr.pop_front());
                void'(exp_data.pop_front());
                matched++;
            end
        end
    end

    // stall cycles of this run
    always @(posedge clk)
    begin
        if (armed && !reset && stall)
            stall_cycles++;
    end

endmodule

/* tb_cardinal_cpu.sv */
`timescale 1ns/1ps

module tb_cardinal_cpu import cardinal_pkg::*; ();

    localparam addr_t base_pc  = 32'h0000_0040;
    localparam addr_t nop_word = {op_nop, 26'd0};

    logic        clk;
    logic        reset;
    addr_t       instr_in;
    data_t       dmem_data_in;
    addr_t       instr_addr;
    addr_t       dmem_addr;
    data_t       dmem_data_out;
    logic        dmem_en;
    logic        dmem_wr_en;
    instr_u      prog [0:63];       // instruction memory
    data_t       dmem [0:255];      // data memory, low address byte picks the word
    logic [31:0] instr_idx;
    logic [31:0] lfsr_state;
    int          tb_errors;
    int          failed_tests;

    cardinal_cpu #(.pc_reset_value(base_pc)) i_cardinal_cpu (
        .clk(clk), .reset(reset), .instr_in(instr_in), .dmem_data_in(dmem_data_in),
        .instr_addr(instr_addr), .dmem_addr(dmem_addr), .dmem_data_out(dmem_data_out),
        .dmem_en(dmem_en), .dmem_wr_en(dmem_wr_en)
    );

    cardinal_scoreboard i_scoreboard (
        .clk(clk), .reset(reset), .stall(i_cardinal_cpu.stall), .dmem_en(dmem_en),
        .dmem_wr_en(dmem_wr_en), .dmem_addr(dmem_addr), .dmem_data_out(dmem_data_out)
    );

    // ------------------------------------------------------------------------
    // memories, instruction side answers in the same cycle
    assign instr_idx = (instr_addr - base_pc) >> 2;
    assign instr_in  = (instr_addr >= base_pc && instr_idx < 64) ? prog[instr_idx] : nop_word;

    always @(posedge clk)
    begin
        if (dmem_en && !reset)
        begin
            if (dmem_wr_en)
                dmem[dmem_addr[24:31]] <= dmem_data_out;
            else
                dmem_data_in <= dmem[dmem_addr[24:31]];  // held until the next access
        end
    end

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ------------------------------------------------------------------------
    // galois lfsr, one step per bit
    function automatic logic [63:0] take_bits(int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'hB4BC_D35C) : (lfsr_state >> 1);
            v = {v[62:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic reg_idx_t pick_reg(int t);
        if (t == 4)
            return reg_idx_t'(1 + take_bits(2) % 3);   // few registers, many dependencies
        return reg_idx_t'(1 + take_bits(5) % 31);
    endfunction

    function automatic ppp_e pick_ppp(int t);
        if (t <= 2)
            return mode_a;
        if (t == 3)
            return ppp_e'(3'(1 + take_bits(2)));      // u, d, e, o only
        return ppp_e'(3'(take_bits(3) % 5));
    endfunction

    // nop prefix, loads to r1..r8, random body, halt at the last word
    function automatic instr_u make_instr(int idx, int t);
        instr_u ins;
        int     roll;
        int     tgt;
        ins = nop_word;
        if (idx >= 4 && idx < 12)
        begin
            ins.m_fmt.opcode = op_ld;
            ins.m_fmt.rd     = reg_idx_t'(idx - 3);
            ins.m_fmt.imm    = 16'(take_bits(16));
        end
        else if (idx == 63)
        begin
            ins.m_fmt.opcode = op_bez;                  // r0 stays zero, so this spins
            ins.m_fmt.rd     = 5'd0;
            ins.m_fmt.imm    = 16'(base_pc + 252);
        end
        else if (idx >= 12)
        begin
            roll = int'(take_bits(4));
            if (t == 5 && roll >= 11)
            begin
                ins.m_fmt.opcode = take_bits(1) ? op_bnez : op_bez;
                ins.m_fmt.rd     = take_bits(1) ? 5'd0 : pick_reg(t);
                tgt = idx + 1 + int'(take_bits(3));     // forward only
                if (tgt > 63)
                    tgt = 63;
                ins.m_fmt.imm    = 16'(base_pc + 4 * tgt);
            end
            else if (roll >= ((t == 6) ? 7 : 12))
            begin
                ins.m_fmt.opcode = take_bits(1) ? op_sd : op_ld;
                ins.m_fmt.rd     = (t == 6 && take_bits(3) == 0) ? 5'd0 : pick_reg(t);
                ins.m_fmt.imm    = 16'(take_bits(16));  // 11 prefix goes to memory too
            end
            else
            begin
                ins.r_fmt.opcode = op_alu;
                ins.r_fmt.rd     = pick_reg(t);         // never r0
                ins.r_fmt.ra     = pick_reg(t);
                ins.r_fmt.rb     = pick_reg(t);
                ins.r_fmt.ppp    = pick_ppp(t);
                ins.r_fmt.ww     = ww_e'(2'(take_bits(2)));
                ins.r_fmt.func   = func_e'(6'(1 + take_bits(3) % 7));
            end
        end
        return ins;
    endfunction

    function automatic int error_total();
        return tb_errors + i_scoreboard.errors + i_cardinal_cpu.i_cardinal_cpu_chk.fail_count;
    endfunction

    // ------------------------------------------------------------------------
    task automatic run_test(int t, string name);
        int errs_before;
        int stores_before;
        int cyc;
        int errs;
        errs_before   = error_total();
        stores_before = i_scoreboard.matched;
        @(posedge clk);
        #1;
        i_scoreboard.armed = 1'b0;
        reset = 1'b1;
        for (int i = 0; i < 64; i++)
        begin
            prog[i] = make_instr(i, t);
            i_scoreboard.prog[i] = prog[i];
        end
        for (int i = 0; i < 256; i++)
        begin
            dmem[i] = take_bits(64);
            i_scoreboard.init_mem[i] = dmem[i];
        end
        i_scoreboard.run_model(base_pc);
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;
        i_scoreboard.armed = 1'b1;
        // pc walks the nop prefix with no memory traffic
        for (int k = 0; k < 5; k++)
        begin
            @(negedge clk);
            if (instr_addr !== addr_t'(base_pc + 4 * k))
            begin
                $display("ERR instr_addr expected %h actual %h", addr_t'(base_pc + 4 * k),
                         instr_addr);
                tb_errors++;
            end
            if (dmem_en !== 1'b0)
            begin
                $display("ERR dmem_en expected 0 actual %h", dmem_en);
                tb_errors++;
            end
        end
        cyc = 0;
        while (instr_addr !== i_scoreboard.halt_pc && cyc < 2000)
        begin
            @(negedge clk);
            cyc++;
        end
        if (cyc >= 2000)
        begin
            $display("test %0d never reached the halt at %h within 2000 cycles", t,
                     i_scoreboard.halt_pc);
            tb_errors++;
        end
        cyc = 0;
        while (i_scoreboard.pending() != 0 && cyc < 64)  // drain stores still in flight
        begin
            @(negedge clk);
            cyc++;
        end
        if (i_scoreboard.pending() != 0)
        begin
            $display("test %0d ended with %0d stores that never came out", t,
                     i_scoreboard.pending());
            tb_errors++;
        end
        repeat (4) @(negedge clk);
        i_scoreboard.check_stalls();
        errs = error_total() - errs_before;
        if (errs != 0)
            failed_tests++;
        $display("test %0d %s: %0d stores matched, %0d errors", t, name,
                 i_scoreboard.matched - stores_before, errs);
    endtask

    initial
    begin
        reset        = 1'b1;
        dmem_data_in = '0;
        lfsr_state   = 32'd81935;
        tb_errors    = 0;
        failed_tests = 0;
        run_test(1, "reset and fetch");
        run_test(2, "alu lane widths");
        run_test(3, "selective writes");
        run_test(4, "forwarding and load use");
        run_test(5, "branches");
        run_test(6, "long mixed program");
        $display("tests 6, failed %0d, errors %0d", failed_tests, error_total());
        if (error_total() == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

/* list.f */
cardinal_pkg.sv
instr_fetch.sv
register_file.sv
decode_stage.sv
execute_stage.sv
result_stage.sv
cardinal_cpu.sv
cardinal_cpu_chk.sv
cardinal_scoreboard.sv
tb_cardinal_cpu.sv
